/* common/mem_if.sv */
`default_nettype none

// load/store strobes between the decoder and the data ram
interface mem_if;

    mmio_pkg::addr_t    waddr;
    mmio_pkg::xlen_t    wdata;
    // already qualified by a ram window hit
    logic               wen;
    mmio_pkg::wr_size_e size;
    mmio_pkg::addr_t    raddr;
    // asynchronous read data
    mmio_pkg::xlen_t    rdata;

    // decoder side
    modport ctrl (output waddr, wdata, wen, size, raddr, input rdata);

    // ram side
    modport ram (input waddr, wdata, wen, size, raddr, output rdata);

endinterface

`default_nettype wire

/* common/mmio_pkg.sv */
`default_nettype none

package mmio_pkg;

    // data word of the load/store bus
    typedef logic [63:0] xlen_t;
    // byte address as seen by the core
    typedef logic [31:0] addr_t;
    // one ps/2 scan code
    typedef logic [7:0] scan_t;
    // eight hex digits for the segment display
    typedef logic [31:0] seg_t;
    typedef logic [15:0] led_t;
    // free running cycle counter value
    typedef logic [63:0] rtc_t;

    // store width
    // lanes follow from this and the low address bits
    typedef enum logic [1:0] {
        SZ_B = 2'd0,
        SZ_H = 2'd1,
        SZ_W = 2'd2,
        SZ_D = 2'd3
    } wr_size_e;

    // address map
    localparam addr_t RAM_BASE = 32'h8000_0000;
    localparam addr_t RTC_ADDR = 32'ha000_0048;
    localparam addr_t KBD_ADDR = 32'ha000_0060;
    localparam addr_t SWT_ADDR = 32'ha000_0070;
    localparam addr_t SEG_ADDR = 32'ha000_0080;
    localparam addr_t LED_ADDR = 32'ha000_0090;

    // every peripheral owns one dword
    localparam addr_t PERI_LEN = 32'd8;

endpackage

`default_nettype wire

/* keyboard/kbd_fifo.sv */
`default_nettype none

module kbd_fifo #(
    parameter int FIFO_DEPTH = 8
) (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            push,
    input  mmio_pkg::scan_t din,
    input  logic            pop,
    output mmio_pkg::scan_t head,
    output logic            not_empty,
    output logic            overflow
);

    localparam int AW = $clog2(FIFO_DEPTH);

    mmio_pkg::scan_t mem [FIFO_DEPTH];
    // extra msb tells a full buffer from an empty one
    logic [AW:0] wptr;
    logic [AW:0] rptr;
    logic        full;
    logic        empty;
    logic        do_push;
    logic        do_pop;

    assign empty = (wptr == rptr);
    assign full  = (wptr[AW] != rptr[AW]) && (wptr[AW-1:0] == rptr[AW-1:0]);

    // pop on empty ignored
    assign do_pop  = pop && !empty;
    // a full buffer still accepts a code when a slot frees in the same cycle
    assign do_push = push && (!full || do_pop);

    // storage
    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wptr[AW-1:0]] <= din;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wptr     <= '0;
            rptr     <= '0;
            overflow <= 1'b0;
        end else begin
            if (do_push) begin
                wptr <= wptr + 1'b1;
            end
            if (do_pop) begin
                rptr <= rptr + 1'b1;
            end
            // sticky until reset
            if (push && !do_push) begin
                overflow <= 1'b1;
            end
        end
    end

    // oldest code shows without a read cycle
    assign head      = mem[rptr[AW-1:0]];
    assign not_empty = !empty;

endmodule

`default_nettype wire

/* keyboard/ps2_rx.sv */
`default_nettype none

module ps2_rx (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            ps2_clk,
    input  logic            ps2_data,
    output mmio_pkg::scan_t code,
    output logic            code_valid
);

    typedef enum logic [1:0] {
        IDLE,
        SHIFT,
        CHECK
    } state_e;

    state_e      state;
    // two flop synchronisers plus one history flop for the clock
    logic [1:0]  clk_sync;
    logic        clk_prev;
    logic [1:0]  data_sync;
    logic        clk_fall;
    // bits taken so far in this frame
    logic [3:0]  bit_cnt;
    // start, data lsb first, parity, stop
    logic [10:0] frame;

    // lines idle high
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            clk_sync  <= 2'b11;
            clk_prev  <= 1'b1;
            data_sync <= 2'b11;
        end else begin
            clk_sync  <= {clk_sync[0], ps2_clk};
            clk_prev  <= clk_sync[1];
            data_sync <= {data_sync[0], ps2_data};
        end
    end

    assign clk_fall = clk_prev & ~clk_sync[1];

    // frame shifter
    // new bit enters at the top so the start bit ends in bit 0
    always_ff @(posedge clk) begin
        if (clk_fall && state != CHECK) begin
            frame <= {data_sync[1], frame[10:1]};
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= IDLE;
            bit_cnt <= '0;
        end else begin
            case (state)
                IDLE: begin
                    // first falling edge carries the start bit
                    if (clk_fall) begin
                        bit_cnt <= 4'd1;
                        state   <= SHIFT;
                    end
                end
                SHIFT: begin
                    if (clk_fall) begin
                        // eleventh bit is the stop bit
                        if (bit_cnt == 4'd10) begin
                            state <= CHECK;
                        end
                        bit_cnt <= bit_cnt + 4'd1;
                    end
                end
                default: begin
                    // one cycle to present the code
                    bit_cnt <= '0;
                    state   <= IDLE;
                end
            endcase
        end
    end

    assign code = frame[8:1];

    // start low, odd parity over data and parity, stop high
    assign code_valid = (state == CHECK) && !frame[0] && (^frame[9:1]) && frame[10];

endmodule

`default_nettype wire

/* mmio_top.f */
common/mmio_pkg.sv
common/mem_if.sv
keyboard/ps2_rx.sv
keyboard/kbd_fifo.sv
src/data_ram.sv
src/mmio.sv
src/mmio_top.sv
verification/mmio_props.sv
verification/mmio_tb.sv

/* src/data_ram.sv */
`default_nettype none

module data_ram #(
    parameter int RAM_WORDS = 256
) (
    input logic clk,
    mem_if.ram  bus
);

    localparam int IW = $clog2(RAM_WORDS);

    mmio_pkg::xlen_t mem [RAM_WORDS];
    logic [IW-1:0]   ridx;
    logic [IW-1:0]   widx;
    logic [2:0]      off;
    // byte lane enables
    logic [7:0]      be;

    // dword index, upper address bits wrap around the depth
    assign ridx = bus.raddr[3 +: IW];
    assign widx = bus.waddr[3 +: IW];
    assign off  = bus.waddr[2:0];

    // lanes from size and offset
    // misaligned low bits get rounded down to the natural boundary
    always_comb begin
        case (bus.size)
            mmio_pkg::SZ_B: be = 8'b0000_0001 << off;
            mmio_pkg::SZ_H: be = 8'b0000_0011 << {off[2:1], 1'b0};
            mmio_pkg::SZ_W: be = 8'b0000_1111 << {off[2], 2'b00};
            default:        be = 8'b1111_1111;
        endcase
    end

    // data already sits in its lanes
    always_ff @(posedge clk) begin
        for (int b = 0; b < 8; b++) begin
            if (bus.wen && be[b]) begin
                mem[widx][8*b +: 8] <= bus.wdata[8*b +: 8];
            end
        end
    end

    // read is combinational
    // same cycle write shows up only after the edge
    assign bus.rdata = mem[ridx];

endmodule

`default_nettype wire

/* src/mmio.sv */
`default_nettype none

module mmio #(
    parameter int RAM_WORDS = 256,
    parameter int RTC_DIV   = 4
) (
    input  logic               clk,
    input  logic               rst_n,
    input  mmio_pkg::addr_t    mem_raddr,
    input  mmio_pkg::addr_t    mem_waddr,
    input  mmio_pkg::xlen_t    mem_wdata,
    input  logic               mem_wen,
    input  logic               mem_ren,
    input  mmio_pkg::wr_size_e wr_size,
    input  mmio_pkg::scan_t    kb_head,
    input  logic               kb_ready,
    input  logic [7:0]         swt,
    mem_if.ctrl                bus,
    output mmio_pkg::xlen_t    mem_rdata,
    output logic               kb_pop,
    output mmio_pkg::seg_t     seg,
    output mmio_pkg::led_t     led
);

    // ram window in bytes
    localparam mmio_pkg::addr_t RAM_LEN = mmio_pkg::addr_t'(8 * RAM_WORDS);
    localparam int DIV_W = (RTC_DIV > 1) ? $clog2(RTC_DIV) : 1;

    logic [DIV_W-1:0] presc;
    mmio_pkg::rtc_t   rtc;

    // unsigned difference so addresses below base wrap high and miss
    function automatic logic hit(mmio_pkg::addr_t a, mmio_pkg::addr_t base,
                                 mmio_pkg::addr_t len);
        return (a - base) < len;
    endfunction

    // loads
    // checked in map order, anything else reads as zero
    always_comb begin
        mem_rdata = '0;
        kb_pop    = 1'b0;
        if (mem_ren) begin
            if (hit(mem_raddr, mmio_pkg::RAM_BASE, RAM_LEN)) begin
                mem_rdata = bus.rdata;
            end else if (hit(mem_raddr, mmio_pkg::KBD_ADDR, mmio_pkg::PERI_LEN)) begin
                // empty buffer reads zero and leaves the pointers alone
                if (kb_ready) begin
                    kb_pop    = 1'b1;
                    mem_rdata = mmio_pkg::xlen_t'(kb_head);
                end
            end else if (hit(mem_raddr, mmio_pkg::SWT_ADDR, mmio_pkg::PERI_LEN)) begin
                mem_rdata = mmio_pkg::xlen_t'(swt);
            end else if (hit(mem_raddr, mmio_pkg::RTC_ADDR, mmio_pkg::PERI_LEN)) begin
                mem_rdata = rtc;
            end
        end
    end

    // ram side of the bus
    assign bus.raddr = mem_raddr;
    assign bus.waddr = mem_waddr;
    assign bus.wdata = mem_wdata;
    assign bus.size  = wr_size;
    // write strobe only inside the ram window
    assign bus.wen   = mem_wen && hit(mem_waddr, mmio_pkg::RAM_BASE, RAM_LEN);

    // stores to the output registers
    // unmapped stores fall through and are lost
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            seg <= '0;
            led <= '0;
        end else if (mem_wen) begin
            if (hit(mem_waddr, mmio_pkg::SEG_ADDR, mmio_pkg::PERI_LEN)) begin
                seg <= mem_wdata[31:0];
            end else if (hit(mem_waddr, mmio_pkg::LED_ADDR, mmio_pkg::PERI_LEN)) begin
                led <= mem_wdata[15:0];
            end
        end
    end

    // real-time counter
    // one tick every RTC_DIV edges
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            presc <= '0;
            rtc   <= '0;
        end else if (presc == DIV_W'(RTC_DIV - 1)) begin
            presc <= '0;
            rtc   <= rtc + 64'd1;
        end else begin
            presc <= presc + 1'b1;
        end
    end

endmodule

`default_nettype wire

/* src/mmio_top.sv */
`default_nettype none

module mmio_top #(
    parameter int RAM_WORDS  = 256,
    parameter int FIFO_DEPTH = 8,
    parameter int RTC_DIV    = 4
) (
    input  logic               clk,
    input  logic               rst_n,
    input  mmio_pkg::addr_t    mem_raddr,
    input  mmio_pkg::addr_t    mem_waddr,
    input  mmio_pkg::xlen_t    mem_wdata,
    input  logic               mem_wen,
    input  logic               mem_ren,
    input  mmio_pkg::wr_size_e wr_size,
    input  logic               ps2_clk,
    input  logic               ps2_data,
    input  logic [7:0]         swt,
    output mmio_pkg::xlen_t    mem_rdata,
    output mmio_pkg::seg_t     seg,
    output mmio_pkg::led_t     led,
    output logic               kbd_overflow
);

    // receiver to buffer
    mmio_pkg::scan_t code;
    logic            code_valid;
    // buffer to decoder
    mmio_pkg::scan_t kb_head;
    logic            kb_ready;
    logic            kb_pop;

    // decoder to ram
    mem_if u_bus ();

    ps2_rx u_ps2_rx (
        .clk        (clk),
        .rst_n      (rst_n),
        .ps2_clk    (ps2_clk),
        .ps2_data   (ps2_data),
        .code       (code),
        .code_valid (code_valid)
    );

    kbd_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_kbd_fifo (
        .clk       (clk),
        .rst_n     (rst_n),
        .push      (code_valid),
        .din       (code),
        .pop       (kb_pop),
        .head      (kb_head),
        .not_empty (kb_ready),
        .overflow  (kbd_overflow)
    );

    mmio #(
        .RAM_WORDS (RAM_WORDS),
        .RTC_DIV   (RTC_DIV)
    ) u_mmio (
        .clk       (clk),
        .rst_n     (rst_n),
        .mem_raddr (mem_raddr),
        .mem_waddr (mem_waddr),
        .mem_wdata (mem_wdata),
        .mem_wen   (mem_wen),
        .mem_ren   (mem_ren),
        .wr_size   (wr_size),
        .kb_head   (kb_head),
        .kb_ready  (kb_ready),
        .swt       (swt),
        .bus       (u_bus.ctrl),
        .mem_rdata (mem_rdata),
        .kb_pop    (kb_pop),
        .seg       (seg),
        .led       (led)
    );

    data_ram #(
        .RAM_WORDS (RAM_WORDS)
    ) u_data_ram (
        .clk (clk),
        .bus (u_bus.ram)
    );

endmodule

`default_nettype wire

/* verification/mmio_props.sv */
`default_nettype none

module mmio_props (
    input logic            clk,
    input logic            rst_n,
    input logic            kb_pop,
    input logic            kb_ready,
    input logic            mem_ren,
    input logic            mem_wen,
    input mmio_pkg::xlen_t mem_rdata,
    input mmio_pkg::addr_t mem_waddr,
    input mmio_pkg::seg_t  seg,
    input mmio_pkg::led_t  led
);

    timeunit 1ns;
    timeprecision 100ps;

    logic seg_store;
    logic led_store;

    // store hits on the two output registers
    assign seg_store = mem_wen && ((mem_waddr - mmio_pkg::SEG_ADDR) < mmio_pkg::PERI_LEN);
    assign led_store = mem_wen && ((mem_waddr - mmio_pkg::LED_ADDR) < mmio_pkg::PERI_LEN);

    // the fifo is only popped when it holds a code
    pop_has_data: assert property (@(posedge clk) disable iff (!rst_n)
        kb_pop |-> kb_ready)
        else $error("keyboard pop while the fifo is empty");

    // idle bus reads as zero
    idle_read_zero: assert property (@(posedge clk) disable iff (!rst_n)
        !mem_ren |-> mem_rdata == '0)
        else $error("read data not zero without a load");

    // output registers move only after their own store
    seg_on_store: assert property (@(posedge clk) disable iff (!rst_n)
        !$stable(seg) |-> $past(seg_store))
        else $error("seg changed without a store to its address");

    led_on_store: assert property (@(posedge clk) disable iff (!rst_n)
        !$stable(led) |-> $past(led_store))
        else $error("led changed without a store to its address");

endmodule

bind mmio mmio_props u_mmio_props (
    .clk       (clk),
    .rst_n     (rst_n),
    .kb_pop    (kb_pop),
    .kb_ready  (kb_ready),
    .mem_ren   (mem_ren),
    .mem_wen   (mem_wen),
    .mem_rdata (mem_rdata),
    .mem_waddr (mem_waddr),
    .seg       (seg),
    .led       (led)
);

`default_nettype wire

/* verification/mmio_tb.sv */
`default_nettype none

module mmio_tb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int RAM_WORDS  = 256;
    localparam int FIFO_DEPTH = 8;
    localparam int RTC_DIV    = 4;
    // test lengths
    localparam int N_INIT  = 16;
    localparam int N_RAM   = 200;
    localparam int N_REG   = 40;
    localparam int N_KBD   = 5;
    localparam int N_BAD   = 2;
    localparam int N_OTHER = 30;
    // ps/2 half period in system cycles
    localparam int HALF      = 6;
    // eleven bits plus idle gap
    localparam int FRAME_CYC = 23 * HALF;
    localparam int N_FRAMES  = N_KBD + N_BAD + FIFO_DEPTH + 2;
    localparam int LIMIT = 2 * (N_INIT + N_RAM) + 2 * N_REG + FRAME_CYC * N_FRAMES
                         + 2 * (N_KBD + FIFO_DEPTH + 4) + N_OTHER + 500;

    logic               clk;
    logic               rst_n;
    mmio_pkg::addr_t    mem_raddr;
    mmio_pkg::addr_t    mem_waddr;
    mmio_pkg::xlen_t    mem_wdata;
    logic               mem_wen;
    logic               mem_ren;
    mmio_pkg::wr_size_e wr_size;
    logic               ps2_clk;
    logic               ps2_data;
    logic [7:0]         swt;
    mmio_pkg::xlen_t    mem_rdata;
    mmio_pkg::seg_t     seg;
    mmio_pkg::led_t     led;
    logic               kbd_overflow;

    // reference model state
    logic [7:0]      ram_img [mmio_pkg::addr_t];
    mmio_pkg::scan_t kq [$];
    logic            ovf_model;
    mmio_pkg::seg_t  seg_model;
    mmio_pkg::led_t  led_model;
    int              rtc_edges;
    int              cycles;
    int              errors;
    logic [31:0]     seed;

    mmio_top #(
        .RAM_WORDS  (RAM_WORDS),
        .FIFO_DEPTH (FIFO_DEPTH),
        .RTC_DIV    (RTC_DIV)
    ) u_mmio_top (
        .clk          (clk),
        .rst_n        (rst_n),
        .mem_raddr    (mem_raddr),
        .mem_waddr    (mem_waddr),
        .mem_wdata    (mem_wdata),
        .mem_wen      (mem_wen),
        .mem_ren      (mem_ren),
        .wr_size      (wr_size),
        .ps2_clk      (ps2_clk),
        .ps2_data     (ps2_data),
        .swt          (swt),
        .mem_rdata    (mem_rdata),
        .seg          (seg),
        .led          (led),
        .kbd_overflow (kbd_overflow)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // edges since reset release feed the counter model
    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rtc_edges <= 0;
        end else begin
            rtc_edges <= rtc_edges + 1;
        end
    end

    // hang guard
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= LIMIT) begin
            $display("timeout: run did not finish within %0d cycles, %0d errors", LIMIT, errors);
            $display("TEST FAIL");
            $finish;
        end
    end

    // xorshift32
    function automatic logic [31:0] next_random();
        seed = seed ^ (seed << 13);
        seed = seed ^ (seed >> 17);
        seed = seed ^ (seed << 5);
        return seed;
    endfunction

    function automatic mmio_pkg::addr_t unmapped_addr(logic [31:0] r);
        // below the ram window or past the last peripheral
        return r[0] ? {20'h00001, r[11:0]} : 32'ha000_0100 + {24'h0, r[8:1]};
    endfunction

    task automatic check_val(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
        if (got !== exp) begin
            errors++;
            $display("Mismatch %s: got %h expected %h", name, got, exp);
        end
    endtask

    // drive point just after the rising edge
    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    // byte lanes from the natural alignment of each size
    task automatic model_store(input mmio_pkg::addr_t a, input mmio_pkg::xlen_t d,
                               input mmio_pkg::wr_size_e sz);
        int              lo;
        int              n;
        mmio_pkg::addr_t base;
        base = a & ~32'h7;
        case (sz)
            mmio_pkg::SZ_B: begin
                lo = a[2:0];
                n  = 1;
            end
            mmio_pkg::SZ_H: begin
                lo = a[2:0] & 3'h6;
                n  = 2;
            end
            mmio_pkg::SZ_W: begin
                lo = a[2:0] & 3'h4;
                n  = 4;
            end
            default: begin
                lo = 0;
                n  = 8;
            end
        endcase
        for (int b = lo; b < lo + n; b++) begin
            ram_img[base + mmio_pkg::addr_t'(b)] = d[8*b +: 8];
        end
    endtask

    function automatic mmio_pkg::xlen_t model_word(mmio_pkg::addr_t a);
        mmio_pkg::xlen_t w;
        mmio_pkg::addr_t base;
        base = a & ~32'h7;
        for (int b = 0; b < 8; b++) begin
            w[8*b +: 8] = ram_img.exists(base + b) ? ram_img[base + b] : 8'hxx;
        end
        return w;
    endfunction

    task automatic store(input mmio_pkg::addr_t a, input mmio_pkg::xlen_t d,
                         input mmio_pkg::wr_size_e sz);
        mem_waddr = a;
        mem_wdata = d;
        wr_size   = sz;
        mem_wen   = 1'b1;
        next_cycle();
        mem_wen = 1'b0;
    endtask

    // rdata is combinational and sampled mid cycle
    task automatic load_and_check(input mmio_pkg::addr_t a, input mmio_pkg::xlen_t exp);
        mem_raddr = a;
        mem_ren   = 1'b1;
        #2;
        check_val("mem_rdata", mem_rdata, exp);
        next_cycle();
        mem_ren = 1'b0;
    endtask

    // start, data lsb first, odd parity, stop
    task automatic send_frame(input mmio_pkg::scan_t c, input logic bad_parity);
        logic [10:0] bits;
        bits = {1'b1, (~^c) ^ bad_parity, c, 1'b0};
        for (int i = 0; i < 11; i++) begin
            ps2_data = bits[i];
            repeat (HALF) next_cycle();
            ps2_clk = 1'b0;
            repeat (HALF) next_cycle();
            ps2_clk = 1'b1;
        end
        ps2_data = 1'b1;
        // gap covers the receive latency
        repeat (HALF) next_cycle();
        if (!bad_parity) begin
            if (kq.size() < FIFO_DEPTH) begin
                kq.push_back(c);
            end else begin
                ovf_model = 1'b1;
            end
        end
    endtask

    task automatic kbd_load();
        mmio_pkg::xlen_t exp;
        exp = (kq.size() > 0) ? mmio_pkg::xlen_t'(kq.pop_front()) : '0;
        load_and_check(mmio_pkg::KBD_ADDR, exp);
    endtask

    initial begin
        logic [31:0]        r;
        mmio_pkg::addr_t    a;
        mmio_pkg::xlen_t    d;
        mmio_pkg::wr_size_e sz;
        seed      = 32'h831d_f707;
        errors    = 0;
        cycles    = 0;
        ovf_model = 1'b0;
        seg_model = '0;
        led_model = '0;
        rst_n     = 1'b0;
        mem_raddr = '0;
        mem_waddr = '0;
        mem_wdata = '0;
        mem_wen   = 1'b0;
        mem_ren   = 1'b0;
        wr_size   = mmio_pkg::SZ_D;
        ps2_clk   = 1'b1;
        ps2_data  = 1'b1;
        swt       = '0;
        repeat (3) @(posedge clk);
        #1;
        rst_n = 1'b1;
        next_cycle();

        // fill the words under test so no lane stays unknown
        for (int w = 0; w < N_INIT; w++) begin
            a = mmio_pkg::RAM_BASE + 32'(w * 8);
            d = {next_random(), next_random()};
            store(a, d, mmio_pkg::SZ_D);
            model_store(a, d, mmio_pkg::SZ_D);
        end

        // sized ram stores with a same cycle load and a load after
        for (int i = 0; i < N_RAM; i++) begin
            r  = next_random();
            a  = mmio_pkg::RAM_BASE + {25'h0, r[3:0], r[6:4]};
            sz = mmio_pkg::wr_size_e'(r[8:7]);
            d  = {next_random(), next_random()};
            mem_raddr = a;
            mem_ren   = 1'b1;
            mem_waddr = a;
            mem_wdata = d;
            wr_size   = sz;
            mem_wen   = 1'b1;
            #2;
            // same cycle load sees the old word
            check_val("mem_rdata", mem_rdata, model_word(a));
            next_cycle();
            mem_wen = 1'b0;
            model_store(a, d, sz);
            load_and_check(a, model_word(a));
        end

        // seg, led and unmapped stores
        for (int i = 0; i < N_REG; i++) begin
            r = next_random();
            d = {next_random(), next_random()};
            case (r[31:30])
                2'd0: begin
                    store(mmio_pkg::SEG_ADDR, d, mmio_pkg::SZ_D);
                    seg_model = d[31:0];
                end
                2'd1: begin
                    store(mmio_pkg::LED_ADDR, d, mmio_pkg::SZ_D);
                    led_model = d[15:0];
                end
                default: store(unmapped_addr(r), d, mmio_pkg::SZ_D);
            endcase
            check_val("seg", seg, seg_model);
            check_val("led", led, led_model);
        end

        // codes come back in arrival order and an empty read gives zero
        for (int i = 0; i < N_KBD; i++) begin
            send_frame(mmio_pkg::scan_t'(next_random()), 1'b0);
        end
        for (int i = 0; i <= N_KBD; i++) begin
            kbd_load();
        end
        check_val("kbd_overflow", kbd_overflow, ovf_model);

        // corrupt frames are dropped
        for (int i = 0; i < N_BAD; i++) begin
            send_frame(mmio_pkg::scan_t'(next_random()), 1'b1);
        end
        kbd_load();
        // two more than fit
        for (int i = 0; i < FIFO_DEPTH + 2; i++) begin
            send_frame(mmio_pkg::scan_t'(next_random()), 1'b0);
        end
        check_val("kbd_overflow", kbd_overflow, ovf_model);
        for (int i = 0; i <= FIFO_DEPTH; i++) begin
            kbd_load();
        end

        // switch, counter and unmapped loads
        for (int i = 0; i < N_OTHER; i++) begin
            r = next_random();
            case (r[31:30])
                2'd0: begin
                    swt = r[7:0];
                    load_and_check(mmio_pkg::SWT_ADDR, {56'h0, r[7:0]});
                end
                2'd1: load_and_check(mmio_pkg::RTC_ADDR, 64'(rtc_edges / RTC_DIV));
                default: load_and_check(unmapped_addr(r), '0);
            endcase
        end

        $display("run finished with %0d errors", errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire
